//--- fifo_ctrl_if.sv
////////////////////////////////////////////////////////////////////////////
// Control and status bundle between the transaction tracker and the
// fetch FIFO. The tracker owns push, pop and flush through modport ctrl.
// The FIFO reports occupancy and empty through modport buffer.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fifo_ctrl_if import prefetch_pkg::*; ();

  // Write one response word into the buffer
  logic push;
  // Drop the head word after the fetch stage took it
  logic pop;
  // Empty the buffer, used on a taken branch
  logic flush;
  // Number of words held
  cnt_t count;
  logic empty;

  // Tracker side
  modport ctrl (
    output push, pop, flush,
    input  count, empty
  );

  // Buffer side
  modport buffer (
    input  push, pop, flush,
    output count, empty
  );

endinterface

//--- files.f
prefetch_pkg.sv
fifo_ctrl_if.sv
pf_addr_gen.sv
pf_txn_tracker.sv
pf_fetch_fifo.sv
prefetch_top.sv
prefetch_props.sv
tb_prefetch.sv

//--- pf_addr_gen.sv
////////////////////////////////////////////////////////////////////////////
// Address generation stage. Presents the next fetch address: the aligned
// branch target on a branch, else the last issued address plus one word.
// A target that is not accepted at once is replayed until it is.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pf_addr_gen import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  addr_t branch_addr_i,
  input  logic  trans_fire_i,
  output addr_t trans_addr_o
);

  pf_state_e state_q, state_d;

  // Last presented address that was a branch target or got accepted
  addr_t addr_q;
  addr_t addr_incr;
  addr_t branch_aligned;

  // Word fetches only, low bits of the target are dropped
  assign branch_aligned = {branch_addr_i[31:2], 2'b00};

  // Register is always word aligned, so a plain add is enough
  assign addr_incr = addr_q + addr_t'(WORD_BYTES);

  //////////////////////////////////////////////////////////////////////////
  // Next address and branch-wait FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    trans_addr_o = addr_incr;
    unique case (state_q)
      IDLE: begin
        if (branch_i) begin
          trans_addr_o = branch_aligned;
          // Target not taken this cycle, hold it for replay
          if (!trans_fire_i) begin
            state_d = BRANCH_WAIT;
          end
        end
      end
      BRANCH_WAIT: begin
        // Replay the pending target, a newer branch overrides it
        trans_addr_o = branch_i ? branch_aligned : addr_q;
        if (trans_fire_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // Capture the target on a branch and every accepted address
      if (branch_i || trans_fire_i) begin
        addr_q <= trans_addr_o;
      end
    end
  end

endmodule

//--- pf_fetch_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Buffering stage. Circular buffer of FIFO_DEPTH response words with an
// occupancy count. When empty, the live response word is forwarded to
// the fetch output so a ready fetch stage sees it in the same cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pf_fetch_fifo import prefetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  instr_t      resp_rdata_i,
  output instr_t      fetch_rdata_o,
  fifo_ctrl_if.buffer fifo
);

  // Word storage
  instr_t mem_q [FIFO_DEPTH];

  ptr_t rd_ptr_q;
  ptr_t wr_ptr_q;
  cnt_t count_q;
  cnt_t count_d;

  logic push_en;
  logic pop_en;

  // Flush takes priority over any other operation that cycle
  assign push_en = fifo.push && !fifo.flush;
  assign pop_en  = fifo.pop && !fifo.flush && (count_q != '0);

  assign fifo.count = count_q;
  assign fifo.empty = (count_q == '0);

  // Head word when something is buffered, bypass otherwise
  assign fetch_rdata_o = fifo.empty ? resp_rdata_i : mem_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case ({push_en, pop_en})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (fifo.flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      count_q <= count_d;
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage write, the word shows at the head one cycle later
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= resp_rdata_i;
    end
  end

endmodule

//--- pf_txn_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Transaction tracking stage. Throttles requests so outstanding plus
// buffered words stay within FIFO_DEPTH, counts responses still due,
// discards those belonging to a stream cut off by a branch and steers
// the remaining ones into the fetch FIFO or straight to the fetch stage.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pf_txn_tracker import prefetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  logic             branch_i,
  input  logic             trans_ready_i,
  input  logic             resp_valid_i,
  input  logic             fetch_ready_i,
  output logic             trans_valid_o,
  output logic             trans_fire_o,
  output logic             fetch_valid_o,
  output logic             busy_o,
  fifo_ctrl_if.ctrl        fifo
);

  // Outstanding transactions
  cnt_t cnt_q, cnt_d;
  // Responses still to be thrown away after a branch
  cnt_t flush_cnt_q, flush_cnt_d;

  cnt_t             fifo_cnt_masked;
  logic [CNT_W:0]   occ_sum;
  logic             fifo_valid;
  logic             drop_resp;

  //////////////////////////////////////////////////////////////////////////
  // Request gating
  //////////////////////////////////////////////////////////////////////////

  // A branch flushes the buffer, so its words do not count this cycle
  assign fifo_cnt_masked = branch_i ? '0 : fifo.count;
  // One extra bit keeps the sum from wrapping
  assign occ_sum         = {1'b0, fifo_cnt_masked} + {1'b0, cnt_q};

  assign trans_valid_o = req_i && (occ_sum < FIFO_DEPTH);
  assign trans_fire_o  = trans_valid_o && trans_ready_i;

  // Work in flight or about to be issued
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  //////////////////////////////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////////////////////////////

  assign fifo_valid = !fifo.empty;
  assign drop_resp  = branch_i || (flush_cnt_q != '0);

  // Buffered word first, else a live response through the bypass
  assign fetch_valid_o = (fifo_valid || resp_valid_i) && !drop_resp;

  assign fifo.flush = branch_i;
  assign fifo.pop   = fifo_valid && fetch_ready_i;
  // Buffer the response unless it goes straight out to a ready fetch stage
  assign fifo.push  = resp_valid_i && !drop_resp && (fifo_valid || !fetch_ready_i);

  //////////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case ({trans_fire_o, resp_valid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      // Everything still outstanding belongs to the old stream
      flush_cnt_d = cnt_q;
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q       <= '0;
      flush_cnt_q <= '0;
    end else begin
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

//--- prefetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, depth constants and types for the instruction prefetch
// unit. Every RTL module and the interface pull these in through a
// wildcard import in their headers.
////////////////////////////////////////////////////////////////////////////

package prefetch_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Depth and width constants
  //////////////////////////////////////////////////////////////////////////

  // Buffer depth, also the cap on outstanding plus buffered words
  localparam int FIFO_DEPTH = 4;

  // Counters must be able to hold FIFO_DEPTH itself
  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  // Buffer pointer width, wraps naturally for a power-of-two depth
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Byte step between sequential word fetches
  localparam int WORD_BYTES = 4;

  //////////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////////

  // Instruction byte address
  typedef logic [31:0] addr_t;

  // Fetched instruction word
  typedef logic [31:0] instr_t;

  // Outstanding count, flush count and buffer occupancy
  typedef logic [CNT_W-1:0] cnt_t;

  // Buffer read and write pointers
  typedef logic [PTR_W-1:0] ptr_t;

  // Address generator states
  typedef enum logic {IDLE, BRANCH_WAIT} pf_state_e;

endpackage

//--- prefetch_props.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions for the prefetch unit, bound into the top level.
// Covers the occupancy limit, address hold under back-pressure and the
// fetch blanking while old responses are discarded.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module prefetch_props import prefetch_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  branch_i,
  input logic  trans_valid_i,
  input logic  trans_ready_i,
  input addr_t trans_addr_i,
  input logic  fetch_valid_i,
  input cnt_t  out_cnt_i,
  input cnt_t  fifo_cnt_i,
  input cnt_t  flush_cnt_i
);

  // Failure tally, read by the testbench at the end
  int unsigned assert_fails = 0;

  // Outstanding plus buffered never above the buffer depth
  a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
    ({1'b0, out_cnt_i} + {1'b0, fifo_cnt_i}) <= FIFO_DEPTH)
    else begin
      $error("outstanding plus buffered words above FIFO_DEPTH");
      assert_fails++;
    end

  // Stalled request keeps its address unless a new branch arrives
  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (trans_valid_i && !trans_ready_i) ##1 !branch_i |-> $stable(trans_addr_i))
    else begin
      $error("request address changed while stalled");
      assert_fails++;
    end

  // Nothing reaches fetch or the buffer while old-stream responses are dropped
  a_flush_blank: assert property (@(posedge clk) disable iff (!rst_n)
    (flush_cnt_i != '0) |-> (!fetch_valid_i && (fifo_cnt_i == '0)))
    else begin
      $error("fetch valid or words buffered while discarding old responses");
      assert_fails++;
    end

endmodule

bind prefetch_top prefetch_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .branch_i      (branch_i),
  .trans_valid_i (trans_valid_o),
  .trans_ready_i (trans_ready_i),
  .trans_addr_i  (trans_addr_o),
  .fetch_valid_i (fetch_valid_o),
  .out_cnt_i     (u_txn_tracker.cnt_q),
  .fifo_cnt_i    (fifo_ctrl.count),
  .flush_cnt_i   (u_txn_tracker.flush_cnt_q)
);

//--- prefetch_top.sv
////////////////////////////////////////////////////////////////////////////
// Instruction prefetch unit top level. Chains address generation,
// transaction tracking and the fetch FIFO, and exposes the request,
// response and fetch channels as plain ports.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module prefetch_top import prefetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // Fetch stage control
  input  logic   req_i,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  output logic   busy_o,
  // Request channel
  output logic   trans_valid_o,
  input  logic   trans_ready_i,
  output addr_t  trans_addr_o,
  // Response channel, always accepted
  input  logic   resp_valid_i,
  input  instr_t resp_rdata_i,
  // Fetch channel
  output logic   fetch_valid_o,
  input  logic   fetch_ready_i,
  output instr_t fetch_rdata_o
);

  // Accepted request, advances the address
  logic trans_fire;

  fifo_ctrl_if fifo_ctrl ();

  pf_addr_gen u_addr_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .trans_fire_i  (trans_fire),
    .trans_addr_o  (trans_addr_o)
  );

  pf_txn_tracker u_txn_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .trans_ready_i (trans_ready_i),
    .resp_valid_i  (resp_valid_i),
    .fetch_ready_i (fetch_ready_i),
    .trans_valid_o (trans_valid_o),
    .trans_fire_o  (trans_fire),
    .fetch_valid_o (fetch_valid_o),
    .busy_o        (busy_o),
    .fifo          (fifo_ctrl.ctrl)
  );

  pf_fetch_fifo u_fetch_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .resp_rdata_i  (resp_rdata_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fifo          (fifo_ctrl.buffer)
  );

endmodule

//--- tb_prefetch.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the instruction prefetch unit. A memory model answers
// requests in order after one to three cycles. A table of branch tests
// is run, and every consumed word and accepted address is compared with
// the sequential stream expected from the branch target.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_prefetch import prefetch_pkg::*; ();

  localparam instr_t DATA_KEY  = 32'h5a5a_0000;
  localparam int     NUM_TESTS = 5;

  // One row per test
  typedef struct packed {
    addr_t      target;
    logic [7:0] words;
    logic       stall;
    logic       rebranch;
  } test_row_t;

  test_row_t tests [NUM_TESTS] = '{
    '{32'h0000_1000, 8'd8,  1'b0, 1'b0},
    '{32'h0000_2a06, 8'd6,  1'b0, 1'b0},
    '{32'h0001_0000, 8'd10, 1'b0, 1'b1},
    '{32'h0000_3000, 8'd12, 1'b1, 1'b0},
    '{32'h0004_4442, 8'd12, 1'b1, 1'b1}
  };

  logic   clk, rst_n, req_i, branch_i, trans_ready_i, resp_valid_i, fetch_ready_i;
  logic   trans_valid_o, busy_o, fetch_valid_o;
  addr_t  branch_addr_i, trans_addr_o;
  instr_t resp_rdata_i, fetch_rdata_o;

  // Memory model state, responses leave in accept order
  addr_t       pend_addr_q [$];
  int          pend_due_q [$];
  int          cyc, last_due;
  logic [31:0] lfsr_q = 32'h7ac3371d;

  // Next expected fetch word address and request address
  addr_t exp_fetch, exp_req;
  int    consumed, n_checks, n_errors;

  prefetch_top u_prefetch_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [3:0] rand_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_instr(input instr_t got, input instr_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // One clock cycle: drive after the edge, sample at the falling edge
  //////////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic req, input logic br, input addr_t br_addr,
                           input logic stall);
    logic [3:0] r;
    int         due;
    @(posedge clk);
    cyc++;
    #2;
    req_i         = req;
    branch_i      = br;
    branch_addr_i = br_addr;
    r             = rand_bits(2);
    // Memory accepts about three cycles in four
    trans_ready_i = (r[1:0] != 2'b00);
    if (stall) begin
      r             = rand_bits(1);
      fetch_ready_i = r[0];
    end else begin
      fetch_ready_i = 1'b1;
    end
    if (pend_addr_q.size() != 0 && pend_due_q[0] <= cyc) begin
      resp_valid_i = 1'b1;
      resp_rdata_i = pend_addr_q.pop_front() ^ DATA_KEY;
      void'(pend_due_q.pop_front());
    end else begin
      resp_valid_i = 1'b0;
      resp_rdata_i = 32'hdead_beef;
    end
    @(negedge clk);
    // Taken branch restarts both streams at the aligned target
    if (br) begin
      exp_fetch = br_addr & 32'hffff_fffc;
      exp_req   = br_addr & 32'hffff_fffc;
    end
    if (trans_valid_o && trans_ready_i) begin
      check_addr(trans_addr_o, exp_req, "request address");
      exp_req = exp_req + 32'd4;
      due     = cyc + 1 + (rand_bits(2) % 3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr_q.push_back(trans_addr_o);
      pend_due_q.push_back(due);
    end
    if (fetch_valid_o && fetch_ready_i) begin
      check_instr(fetch_rdata_o, exp_fetch ^ DATA_KEY, "fetch word");
      exp_fetch = exp_fetch + 32'd4;
      consumed++;
    end
  endtask

  // Branch, consume the words, optionally branch again, then drain
  task automatic run_test(input int t);
    test_row_t row;
    int        err0;
    logic      rebranched;
    row        = tests[t];
    err0       = n_errors;
    consumed   = 0;
    rebranched = 1'b0;
    run_cycle(1'b1, 1'b1, row.target, row.stall);
    while (consumed < row.words) begin
      if (row.rebranch && !rebranched && consumed >= row.words / 2) begin
        rebranched = 1'b1;
        // Unaligned second target while old responses are in flight
        run_cycle(1'b1, 1'b1, row.target + 32'h0000_0102, row.stall);
      end else begin
        run_cycle(1'b1, 1'b0, '0, row.stall);
      end
    end
    while (pend_addr_q.size() != 0) begin
      run_cycle(1'b0, 1'b0, '0, row.stall);
    end
    run_cycle(1'b0, 1'b0, '0, row.stall);
    check_flag(busy_o, 1'b0, "busy after drain");
    $display("Test %0d target %h words %0d stall %0b rebranch %0b: %0d errors",
             t, row.target, row.words, row.stall, row.rebranch, n_errors - err0);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    trans_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    fetch_ready_i = 1'b0;
    cyc           = 0;
    last_due      = 0;
    n_checks      = 0;
    n_errors      = 0;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    run_cycle(1'b0, 1'b0, '0, 1'b0);
    check_flag(trans_valid_o, 1'b0, "trans_valid_o after reset");
    check_flag(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
    check_flag(busy_o, 1'b0, "busy_o after reset");
    $display("Test reset idle: %0d errors", n_errors);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    n_errors += u_prefetch_top.u_props.assert_fails;
    $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Limit is 40 cycles per table word plus 200 cycles of margin
  initial begin : watchdog
    int unsigned limit;
    limit = 200;
    foreach (tests[i]) begin
      limit += tests[i].words * 40;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Verification failed");
    $finish;
  end

endmodule
